// ==== Makefile ====
# Verilator build and run for the 64b/66b lane aligner testbench

VERILATOR ?= verilator
TOP       ?= tb_pcs_rx_align
FILELIST  ?= pcs_rx_align.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# a $fatal in the testbench gives a non-zero exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// ==== block_aligner/block_sync_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module block_sync_fsm
    import pcs_rx_pkg::*;
(
    input  wire                  i_clock,
    input  wire                  i_rst_n,
    input  wire                  i_valid,
    input  wire                  i_signal_ok,
    input  wire                  i_sh_valid,
    output logic [NB_OFFSET-1:0] o_offset,
    output logic                 o_block_lock
);

    typedef enum logic {
        UNLOCKED,
        LOCKED
    } sync_state_t;

    sync_state_t               state;
    logic [NB_OFFSET-1:0]      offset;
    logic [NB_OFFSET-1:0]      offset_slip;
    logic [NB_GOOD_CNT-1:0]    good_cnt;
    logic [NB_WINDOW_CNT-1:0]  timer;
    logic [NB_INVALID_CNT-1:0] invalid_cnt;
    logic [NB_INVALID_CNT-1:0] invalid_next;

    // next search position with 65 wrapping to 0
    assign offset_slip  = (offset == NB_OFFSET'(NB_BLOCK - 1)) ? '0 : offset + 1'b1;
    assign invalid_next = invalid_cnt + {{(NB_INVALID_CNT-1){1'b0}}, ~i_sh_valid};

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state       <= UNLOCKED;
            offset      <= '0;
            good_cnt    <= '0;
            timer       <= '0;
            invalid_cnt <= '0;
        end
        else if (!i_signal_ok)
        begin
            // signal loss restarts the search from offset 0
            state       <= UNLOCKED;
            offset      <= '0;
            good_cnt    <= '0;
            timer       <= '0;
            invalid_cnt <= '0;
        end
        else if (i_valid)
        begin
            case (state)
                UNLOCKED:
                begin
                    if (!i_sh_valid)
                    begin
                        good_cnt <= '0;
                        offset   <= offset_slip;        // try the next bit position
                    end
                    else if (good_cnt == NB_GOOD_CNT'(SH_LOCK_COUNT - 1))
                    begin
                        state       <= LOCKED;
                        good_cnt    <= '0;
                        timer       <= '0;
                        invalid_cnt <= '0;
                    end
                    else
                        good_cnt <= good_cnt + 1'b1;
                end
                LOCKED:
                begin
                    if (invalid_next == NB_INVALID_CNT'(SH_INVALID_LIMIT))
                    begin
                        state       <= UNLOCKED;
                        offset      <= offset_slip;
                        timer       <= '0;
                        invalid_cnt <= '0;
                    end
                    else if (timer == NB_WINDOW_CNT'(SH_CHECK_WINDOW - 1))
                    begin
                        timer       <= '0;              // window done so start fresh
                        invalid_cnt <= '0;
                    end
                    else
                    begin
                        timer       <= timer + 1'b1;
                        invalid_cnt <= invalid_next;
                    end
                end
                default: state <= UNLOCKED;
            endcase
        end
    end

    assign o_offset     = offset;
    assign o_block_lock = (state == LOCKED);

    a_offset_range: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        o_offset < NB_OFFSET'(NB_BLOCK))
        else $error("block sync offset out of range");

    // signal still present in the cycle where lock appears
    a_lock_needs_signal: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        $rose(o_block_lock) |-> i_signal_ok)
        else $error("block lock rose without signal_ok");

endmodule

`default_nettype wire

// ==== block_aligner/lane_block_aligner.sv ====
`timescale 1ns/1ns
`default_nettype none

module lane_block_aligner
    import pcs_rx_pkg::*;
(
    input  wire     i_clock,
    input  wire     i_rst_n,
    lane_if.sink    i_raw,
    lane_if.source  o_blk
);

    raw_word_t            prev_word;
    logic [NB_PAIR-1:0]   pair;
    block_t               candidate;
    logic                 sh_valid;
    logic [NB_OFFSET-1:0] offset;
    logic                 block_lock;

    // earlier word in the low half, stream bit 0 first
    assign pair      = {i_raw.data, prev_word};
    assign candidate = pair[offset +: NB_BLOCK];
    assign sh_valid  = candidate.sh[1] ^ candidate.sh[0];  // 01 or 10

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            prev_word <= '0;
        else if (i_raw.valid)
            prev_word <= i_raw.data;
    end

    block_sync_fsm u_sync (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_raw.valid),
        .i_signal_ok  (i_raw.signal_ok),
        .i_sh_valid   (sh_valid),
        .o_offset     (offset),
        .o_block_lock (block_lock)
    );

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
            o_blk.valid <= 1'b0;
        else
            o_blk.valid <= i_raw.valid;
    end

    // block at the offset in use for this word
    always_ff @(posedge i_clock)
    begin
        if (i_raw.valid)
            o_blk.data <= candidate;
    end

    assign o_blk.lock      = block_lock;        // fsm state, same edge as valid
    assign o_blk.signal_ok = i_raw.signal_ok;

endmodule

`default_nettype wire

// ==== common/lane_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// one lane of the receive stream, payload type set per instance
interface lane_if
    import pcs_rx_pkg::*;
#(
    parameter type T = raw_word_t
)
();

    logic valid;        // single-cycle strobe, no back-pressure
    T     data;
    logic signal_ok;
    logic lock;         // block lock, tied low on raw lanes

    modport source (
        output valid,
        output data,
        output signal_ok,
        output lock
    );

    modport sink (
        input valid,
        input data,
        input signal_ok,
        input lock
    );

endinterface

`default_nettype wire

// ==== common/pcs_rx_pkg.sv ====
`default_nettype none

package pcs_rx_pkg;

    // lane and block geometry
    localparam int NUM_LANES = 4;
    localparam int NB_BLOCK  = 66;
    localparam int NB_OFFSET = 7;                   // holds 0..65
    localparam int NB_PAIR   = 2 * NB_BLOCK;        // previous + current word
    localparam int NB_BUS    = NUM_LANES * NB_BLOCK;

    // lock limits
    localparam int SH_LOCK_COUNT    = 64;           // good headers in a row
    localparam int SH_CHECK_WINDOW  = 1024;         // words per locked window
    localparam int SH_INVALID_LIMIT = 16;           // bad headers per window

    // counter widths
    localparam int NB_GOOD_CNT    = $clog2(SH_LOCK_COUNT);
    localparam int NB_WINDOW_CNT  = $clog2(SH_CHECK_WINDOW);
    localparam int NB_INVALID_CNT = $clog2(SH_INVALID_LIMIT + 1);

    // raw gearbox word, not yet aligned
    typedef logic [NB_BLOCK-1:0] raw_word_t;

    // aligned coded block, sync header in bits 1:0
    typedef struct packed {
        logic [NB_BLOCK-3:0] payload;
        logic [1:0]          sh;
    } block_t;

endpackage

`default_nettype wire

// ==== pcs_rx_align.f ====
common/pcs_rx_pkg.sv
common/lane_if.sv
rtl/rx_lane_splitter.sv
block_aligner/block_sync_fsm.sv
block_aligner/lane_block_aligner.sv
rtl/rx_lane_merger.sv
rtl/pcs_rx_align_top.sv
test/tb_pcs_rx_align.sv

// ==== rtl/pcs_rx_align_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pcs_rx_align_top
    import pcs_rx_pkg::*;
(
    input  wire                   i_clock,
    input  wire                   i_rst_n,
    input  wire                   i_valid,
    input  wire  [NB_BUS-1:0]     i_data,
    input  wire  [NUM_LANES-1:0]  i_signal_ok,
    output logic                  o_valid,
    output logic [NB_BUS-1:0]     o_data,
    output logic [NUM_LANES-1:0]  o_lane_lock,
    output logic                  o_link_up
);

    lane_if #(.T(raw_word_t)) raw_lanes [NUM_LANES] ();
    lane_if #(.T(block_t))    blk_lanes [NUM_LANES] ();

    rx_lane_splitter u_splitter (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .i_data      (i_data),
        .i_signal_ok (i_signal_ok),
        .o_lanes     (raw_lanes)
    );

    // one independent aligner per lane
    for (genvar g = 0; g < NUM_LANES; g++)
    begin : g_align
        lane_block_aligner u_aligner (
            .i_clock (i_clock),
            .i_rst_n (i_rst_n),
            .i_raw   (raw_lanes[g]),
            .o_blk   (blk_lanes[g])
        );
    end

    rx_lane_merger u_merger (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_lanes     (blk_lanes),
        .o_valid     (o_valid),
        .o_data      (o_data),
        .o_lane_lock (o_lane_lock),
        .o_link_up   (o_link_up)
    );

endmodule

`default_nettype wire

// ==== rtl/rx_lane_merger.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_lane_merger
    import pcs_rx_pkg::*;
(
    input  wire                   i_clock,
    input  wire                   i_rst_n,
    lane_if.sink                  i_lanes [NUM_LANES],
    output logic                  o_valid,
    output logic [NB_BUS-1:0]     o_data,
    output logic [NUM_LANES-1:0]  o_lane_lock,
    output logic                  o_link_up
);

    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] lane_lock;
    logic [NUM_LANES-1:0] lane_ok;
    logic [NB_BUS-1:0]    lane_data;

    for (genvar g = 0; g < NUM_LANES; g++)
    begin : g_lane
        assign lane_valid[g]                     = i_lanes[g].valid;
        assign lane_lock[g]                      = i_lanes[g].lock;
        assign lane_ok[g]                        = i_lanes[g].signal_ok;
        assign lane_data[g*NB_BLOCK +: NB_BLOCK] = i_lanes[g].data;
    end

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_valid     <= 1'b0;
            o_lane_lock <= '0;
            o_link_up   <= 1'b0;
        end
        else
        begin
            o_valid     <= lane_valid[0];           // lanes run in lockstep
            o_lane_lock <= lane_lock & lane_ok;
            o_link_up   <= &(lane_lock & lane_ok);  // every lane locked
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (lane_valid[0])
            o_data <= lane_data;
    end

    // one splitter strobe fans out to all aligners
    a_lanes_in_step: assert property (@(posedge i_clock) disable iff (!i_rst_n)
        lane_valid == {NUM_LANES{lane_valid[0]}})
        else $error("lane valids differ: %b", lane_valid);

endmodule

`default_nettype wire

// ==== rtl/rx_lane_splitter.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_lane_splitter
    import pcs_rx_pkg::*;
(
    input  wire                  i_clock,
    input  wire                  i_rst_n,
    input  wire                  i_valid,
    input  wire [NB_BUS-1:0]     i_data,
    input  wire [NUM_LANES-1:0]  i_signal_ok,
    lane_if.source               o_lanes [NUM_LANES]
);

    logic                 valid_q;
    logic [NB_BUS-1:0]    data_q;
    logic [NUM_LANES-1:0] signal_ok_q;

    always_ff @(posedge i_clock or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            valid_q     <= 1'b0;
            signal_ok_q <= '0;
        end
        else
        begin
            valid_q     <= i_valid;
            signal_ok_q <= i_signal_ok;     // follows every clock, strobe or not
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
            data_q <= i_data;
    end

    // lane 0 sits in the low bits of the bus
    for (genvar g = 0; g < NUM_LANES; g++)
    begin : g_lane
        assign o_lanes[g].valid     = valid_q;
        assign o_lanes[g].data      = data_q[g*NB_BLOCK +: NB_BLOCK];
        assign o_lanes[g].signal_ok = signal_ok_q[g];
        assign o_lanes[g].lock      = 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/rx_input.txt ====
# off0 off1 off2 off3 words inj_lane inj_start inj_count drop_lane drop_word drop_cycles gap_pct expect_drop
# offsets in bits 0..65, lane -1 means none, gap_pct is the idle chance before a word in percent
0 0 0 0 800 -1 0 0 -1 0 0 0 0
17 33 50 65 1200 -1 0 0 -1 0 0 20 0
5 40 12 61 2000 2 600 15 -1 0 0 0 0
23 1 64 9 2000 1 600 16 -1 0 0 10 1
44 8 30 2 2000 -1 0 0 3 1000 12 0 0
63 31 7 48 2500 0 600 16 2 1400 8 35 1

// ==== test/tb_pcs_rx_align.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pcs_rx_align
    import pcs_rx_pkg::*;
();

    localparam int CLK_HALF   = 4;
    localparam int LOCK_BOUND = NB_BLOCK * SH_LOCK_COUNT + NB_BLOCK;   // strobes

    logic                 i_clock;
    logic                 i_rst_n;
    logic                 i_valid;
    logic [NB_BUS-1:0]    i_data;
    logic [NUM_LANES-1:0] i_signal_ok;
    logic                 o_valid;
    logic [NB_BUS-1:0]    o_data;
    logic [NUM_LANES-1:0] o_lane_lock;
    logic                 o_link_up;

    // scenario fields from one input line at a time
    int off [NUM_LANES];
    int n_words, inj_lane, inj_start, inj_count;
    int drop_lane, drop_word, drop_cycles, gap_pct, expect_drop;

    // transmit side and monitor state
    logic [NB_BLOCK-1:0]  sent_q [NUM_LANES][$];
    logic [NB_PAIR-1:0]   acc [NUM_LANES];          // bits not yet cut into words
    int                   acc_bits [NUM_LANES];
    int                   lag [NUM_LANES];          // -1 until first locked block
    int                   drops [NUM_LANES];
    logic [NUM_LANES-1:0] prev_lock;
    logic [2:0]           v_hist;
    int                   in_count, out_count, fail_count;
    longint               timeout_ns;
    string                lines [$];

    pcs_rx_align_top i_dut (
        .i_clock     (i_clock),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .i_data      (i_data),
        .i_signal_ok (i_signal_ok),
        .o_valid     (o_valid),
        .o_data      (o_data),
        .o_lane_lock (o_lane_lock),
        .o_link_up   (o_link_up)
    );

    always #CLK_HALF i_clock = ~i_clock;

    task automatic check_value(input string name, input logic [NB_BLOCK-1:0] got,
                               input logic [NB_BLOCK-1:0] exp);
        if (got !== exp)
        begin
            fail_count++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic next_cycle();
        @(posedge i_clock);
        #1;
    endtask

    task automatic parse_line(input string line);
        int n;
        n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d",
                    off[0], off[1], off[2], off[3], n_words, inj_lane, inj_start,
                    inj_count, drop_lane, drop_word, drop_cycles, gap_pct, expect_drop);
        if (n != 13)
        begin
            $display("scenario line could not be read: %s", line);
            $display("FAIL: see errors above");
            $fatal(1, "bad scenario file");
        end
    endtask

    // cut the next 66-bit gearbox word out of a lane's bit stream
    task automatic next_word(input int lane, output logic [NB_BLOCK-1:0] word);
        logic [NB_BLOCK-1:0] blk;
        int idx;
        while (acc_bits[lane] < NB_BLOCK)
        begin
            idx = sent_q[lane].size();
            blk = {$urandom, $urandom, ((($urandom & 1) != 0) ? 2'b01 : 2'b10)};
            if (lane == inj_lane && idx >= inj_start && idx < inj_start + inj_count)
                blk[1:0] = {blk[0], blk[0]};            // bad header 00 or 11
            sent_q[lane].push_back(blk);
            acc[lane] = acc[lane] | (NB_PAIR'(blk) << acc_bits[lane]);
            acc_bits[lane] += NB_BLOCK;
        end
        word = acc[lane][NB_BLOCK-1:0];
        acc[lane] = acc[lane] >> NB_BLOCK;
        acc_bits[lane] -= NB_BLOCK;
    endtask

    task automatic apply_reset();
        i_rst_n     = 1'b0;
        i_valid     = 1'b0;
        i_signal_ok = '1;
        repeat (10) next_cycle();
        i_rst_n = 1'b1;
        check_value("o_valid", o_valid, 0);
        check_value("o_lane_lock", o_lane_lock, 0);
        check_value("o_link_up", o_link_up, 0);
    endtask

    // lock must go within three cycles with no strobes meanwhile
    task automatic signal_drop();
        check_value("o_lane_lock before signal loss", o_lane_lock[drop_lane], 1);
        i_valid                = 1'b0;
        i_signal_ok[drop_lane] = 1'b0;
        repeat (3) next_cycle();
        check_value("o_lane_lock after signal loss", o_lane_lock[drop_lane], 0);
        repeat (drop_cycles - 3) next_cycle();
        i_signal_ok[drop_lane] = 1'b1;
    endtask

    task automatic run_scenario(input int num);
        logic [NB_BLOCK-1:0] word;
        int idle;
        apply_reset();
        for (int l = 0; l < NUM_LANES; l++)
        begin
            // random filler ahead of the first block sets the bit offset
            acc[l] = NB_PAIR'({$urandom, $urandom, $urandom}) & ((NB_PAIR'(1) << off[l]) - 1'b1);
            acc_bits[l] = off[l];
        end
        for (int w = 0; w < n_words; w++)
        begin
            if (w == drop_word && drop_lane >= 0)
                signal_drop();
            if (($urandom % 100) < gap_pct)
            begin
                idle    = 1 + int'($urandom % 3);
                i_valid = 1'b0;
                repeat (idle) next_cycle();
            end
            for (int l = 0; l < NUM_LANES; l++)
            begin
                next_word(l, word);
                i_data[l*NB_BLOCK +: NB_BLOCK] = word;
            end
            i_valid = 1'b1;
            next_cycle();
        end
        i_valid = 1'b0;
        repeat (6) next_cycle();                      // let the pipeline drain
        $display("scenario %0d: %0d words, lag %0d", num, n_words, lag[0]);
        check_value("o_valid pulse count", out_count, in_count);
        check_value("o_valid pulses per word", out_count, n_words);
        check_value("o_lane_lock at end", o_lane_lock, {NUM_LANES{1'b1}});
        check_value("o_link_up at end", o_link_up, 1);
        for (int l = 0; l < NUM_LANES; l++)
            check_value($sformatf("lock drop seen on lane %0d", l), drops[l] > 0,
                        (l == inj_lane && expect_drop != 0) || l == drop_lane);
    endtask

    task automatic check_lane_block(input int lane);
        logic [NB_BLOCK-1:0] got;
        int idx;
        got = o_data[lane*NB_BLOCK +: NB_BLOCK];
        if (lag[lane] < 0)
        begin
            check_value($sformatf("lane %0d locked within bound", lane),
                        out_count <= LOCK_BOUND, 1);
            for (int j = 0; j < sent_q[lane].size() && lag[lane] < 0; j++)
                if (sent_q[lane][j] == got)
                    lag[lane] = out_count - j;
            check_value($sformatf("lane %0d first block found", lane), lag[lane] >= 0, 1);
        end
        idx = out_count - lag[lane];
        check_value($sformatf("lane %0d block sent", lane), idx < sent_q[lane].size(), 1);
        check_value($sformatf("o_data lane %0d", lane), got, sent_q[lane][idx]);
    endtask

    // outputs sampled mid-cycle away from both edges
    always @(negedge i_clock)
    begin
        if (!i_rst_n)
        begin
            for (int l = 0; l < NUM_LANES; l++)
            begin
                sent_q[l].delete();
                lag[l]   = -1;
                drops[l] = 0;
            end
            prev_lock = '0;
            v_hist    = '0;
            in_count  = 0;
            out_count = 0;
        end
        else
        begin
            check_value("o_valid", o_valid, v_hist[2]);     // three cycles after i_valid
            check_value("o_link_up", o_link_up, &o_lane_lock);
            v_hist = {v_hist[1:0], i_valid};
            if (i_valid)
                in_count++;
            for (int l = 0; l < NUM_LANES; l++)
            begin
                if (prev_lock[l] && !o_lane_lock[l])
                    drops[l]++;
                if (o_valid && o_lane_lock[l])
                    check_lane_block(l);
            end
            prev_lock = o_lane_lock;
            if (o_valid)
                out_count++;
        end
    end

    initial
    begin
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("watchdog expired after %0d ns, the DUT stopped making progress", timeout_ns);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog timeout");
    end

    initial
    begin
        string  line;
        int     fd;
        longint total_cycles;
        i_clock     = 1'b0;
        i_rst_n     = 1'b0;
        i_valid     = 1'b0;
        i_data      = '0;
        i_signal_ok = '0;
        fail_count  = 0;
        void'($urandom(32'hf5fd2388));
        fd = $fopen("test/rx_input.txt", "r");
        if (fd == 0)
        begin
            $display("could not open test/rx_input.txt");
            $display("FAIL: see errors above");
            $fatal(1, "missing scenario file");
        end
        while (!$feof(fd))
        begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#")
                lines.push_back(line);
        end
        $fclose(fd);
        total_cycles = 1000;
        foreach (lines[i])
        begin
            parse_line(lines[i]);
            total_cycles += 4 * n_words + drop_cycles + 30;   // worst case gaps
        end
        timeout_ns = total_cycles * 2 * CLK_HALF;
        foreach (lines[i])
        begin
            parse_line(lines[i]);
            run_scenario(i);
        end
        if (fail_count == 0)
        begin
            $display("PASS: all tests");
            $finish;
        end
        else
        begin
            $display("FAIL: see errors above");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire
